/* common/motion_types_pkg.sv */
package motion_types_pkg;

  // Host command and response word
  typedef logic [63:0] word_t;

  // Axis position in whole steps
  typedef logic signed [31:0] step_pos_t;

  // Move length in DDA ticks
  typedef logic [31:0] duration_t;

  // Accumulator increment, also used for its per-tick change
  typedef logic signed [63:0] increment_t;

  // One DDA tick every clk_div+1 clocks
  typedef logic [7:0] clk_div_t;

  // Accumulator level that owes one step (2^32)
  localparam increment_t DDA_THRESHOLD = 64'h0000_0001_0000_0000;

endpackage

/* common/motion_cmd_pkg.sv */
package motion_cmd_pkg;

  // Host opcodes, top byte of a header word
  typedef enum logic [7:0] {
    CMD_NOP         = 8'd0,
    CMD_ENABLE      = 8'd1,
    CMD_CLK_DIVISOR = 8'd2,
    CMD_MOVE        = 8'd3,
    CMD_SNAPSHOT    = 8'd4,
    CMD_READ_POS    = 8'd5,
    CMD_VERSION     = 8'd6
  } cmd_opcode_t;

  // Opcode field is bits OPCODE_MSB down to OPCODE_MSB-7
  localparam int OPCODE_MSB = 63;

  // First direction bit of a move header, one bit per axis upward
  localparam int MOVE_DIR_LSB = 32;

  // Reported by CMD_VERSION, major in the highest byte
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

endpackage

/* common/move_if.sv */
`timescale 1ns/1ps

// One coordinated move, decoder to a single axis
interface move_if
  import motion_types_pkg::*;
();

  logic       load;      // One-cycle pulse, only while busy is low
  logic       dir;
  duration_t  duration;
  increment_t increment;
  increment_t accel;     // Added to increment after every tick
  logic       busy;

  modport decoder (
    output load,
    output dir,
    output duration,
    output increment,
    output accel,
    input  busy
  );

  modport axis (
    input  load,
    input  dir,
    input  duration,
    input  increment,
    input  accel,
    output busy
  );

endinterface

/* verilog/cmd_decoder/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder
  import motion_types_pkg::*;
  import motion_cmd_pkg::*;
#(
  parameter int NUM_AXES = 3
) (
  input  logic          CLK,
  input  logic          rst_n,
  input  logic          req,
  input  word_t         word_in,
  output logic          ack,
  output word_t         rsp_word,
  output logic          drivers_enable,
  output logic          moves_idle,
  output clk_div_t      clk_div,
  output logic          snap,
  output logic [2:0]    rd_axis,
  input  step_pos_t     rd_pos,
  move_if.decoder       mv [NUM_AXES]
);

  // Payload words of a move, increment and accel per axis
  localparam int CNT_W = $clog2(2 * NUM_AXES + 1);
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(2 * NUM_AXES - 1);

  typedef enum logic [1:0] {IDLE, ACK_HI, WAIT_REQ_LO, WAIT_AXES} state_t;

  state_t            state;
  word_t             word_r;
  cmd_opcode_t       op;
  cmd_opcode_t       hdr_op;   // CMD_MOVE while payload words are pending
  logic [CNT_W-1:0]  word_cnt;
  logic              load_r;
  logic              all_idle;
  logic [NUM_AXES-1:0] busy_vec;
  logic [NUM_AXES-1:0] dir_stage;
  duration_t         dur_stage;
  increment_t        inc_stage [NUM_AXES];
  increment_t        acc_stage [NUM_AXES];

  assign op         = cmd_opcode_t'(word_r[OPCODE_MSB -: 8]);
  assign rd_axis    = word_r[2:0];
  assign all_idle   = ~|busy_vec;
  assign moves_idle = all_idle & ~load_r;  // Covers the cycle before busy rises

  for (genvar i = 0; i < NUM_AXES; i++) begin : g_mv
    assign mv[i].load      = load_r;
    assign mv[i].dir       = dir_stage[i];
    assign mv[i].duration  = dur_stage;
    assign mv[i].increment = inc_stage[i];
    assign mv[i].accel     = acc_stage[i];
    assign busy_vec[i]     = mv[i].busy;

    a_no_load_busy: assert property (@(posedge CLK) disable iff (!rst_n)
      load_r |-> !busy_vec[i]);
  end

  // Word latch and move staging
  always_ff @(posedge CLK) begin
    if (state == IDLE && req) begin
      word_r <= word_in;
    end
    if (state == ACK_HI) begin
      if (hdr_op == CMD_MOVE) begin
        if (word_cnt[0]) begin
          acc_stage[word_cnt[CNT_W-1:1]] <= word_r;
        end else begin
          inc_stage[word_cnt[CNT_W-1:1]] <= word_r;
        end
      end else if (op == CMD_MOVE) begin
        dir_stage <= word_r[MOVE_DIR_LSB +: NUM_AXES];
        dur_stage <= word_r[31:0];
      end
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state          <= IDLE;
      ack            <= 1'b0;
      rsp_word       <= '0;
      drivers_enable <= 1'b0;
      clk_div        <= 8'd39;
      snap           <= 1'b0;
      load_r         <= 1'b0;
      hdr_op         <= CMD_NOP;
      word_cnt       <= '0;
    end else begin
      snap   <= 1'b0;
      load_r <= 1'b0;
      case (state)
        IDLE: begin
          if (req) begin
            state <= ACK_HI;
          end
        end
        ACK_HI: begin
          rsp_word <= '0;
          if (hdr_op == CMD_MOVE) begin
            if (word_cnt == LAST_WORD) begin
              hdr_op   <= CMD_NOP;
              word_cnt <= '0;
              state    <= WAIT_AXES;  // Hold ack until every axis is free
            end else begin
              word_cnt <= word_cnt + 1'b1;
              ack      <= 1'b1;
              state    <= WAIT_REQ_LO;
            end
          end else begin
            ack   <= 1'b1;
            state <= WAIT_REQ_LO;
            case (op)
              CMD_ENABLE:      drivers_enable <= word_r[0];
              CMD_CLK_DIVISOR: clk_div <= word_r[7:0];
              CMD_MOVE: begin
                hdr_op   <= CMD_MOVE;
                word_cnt <= '0;
              end
              CMD_SNAPSHOT:    snap <= 1'b1;
              CMD_READ_POS:    rsp_word <= {{32{rd_pos[31]}}, rd_pos};
              CMD_VERSION:
                rsp_word <= {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
              default: ;  // NOP and unknown codes just ack
            endcase
          end
        end
        WAIT_AXES: begin
          if (all_idle) begin
            load_r <= 1'b1;  // All axes start together
            ack    <= 1'b1;
            state  <= WAIT_REQ_LO;
          end
        end
        WAIT_REQ_LO: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_ack_after_req: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(ack) |-> $past(req));

endmodule

/* verilog/dda_axis/dda_axis.sv */
`timescale 1ns/1ps

module dda_axis
  import motion_types_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  clk_div_t  clk_div,
  move_if.axis      mv,
  output logic      step,
  output logic      dir,
  output step_pos_t position
);

  clk_div_t   clk_cnt;     // Clocks left until the next tick
  duration_t  ticks_left;
  increment_t accum;       // Residue survives across moves
  increment_t inc_r;
  increment_t acc_r;
  increment_t sum;
  logic       tick;

  assign tick = mv.busy && (ticks_left != '0) && (clk_cnt == '0);
  assign sum  = accum + inc_r;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mv.busy    <= 1'b0;
      step       <= 1'b0;
      dir        <= 1'b0;
      clk_cnt    <= '0;
      ticks_left <= '0;
      accum      <= '0;
      position   <= '0;
    end else begin
      step <= 1'b0;
      if (mv.load) begin
        mv.busy    <= 1'b1;
        dir        <= mv.dir;
        ticks_left <= mv.duration;
        clk_cnt    <= clk_div;
      end else if (mv.busy) begin
        if (ticks_left == '0) begin
          mv.busy <= 1'b0;  // One idle cycle after the last tick
        end else if (tick) begin
          clk_cnt    <= clk_div;
          ticks_left <= ticks_left - 1'b1;
          if (sum >= DDA_THRESHOLD) begin
            accum <= sum - DDA_THRESHOLD;
            step  <= 1'b1;
            // dir high counts up
            position <= dir ? position + 1'b1 : position - 1'b1;
          end else begin
            accum <= sum;
          end
        end else begin
          clk_cnt <= clk_cnt - 1'b1;
        end
      end
    end
  end

  // Rate and ramp of the current move
  always_ff @(posedge CLK) begin
    if (mv.load) begin
      inc_r <= mv.increment;
      acc_r <= mv.accel;
    end else if (tick) begin
      inc_r <= inc_r + acc_r;
    end
  end

  // A tick never owes more than one step
  a_one_step_per_tick: assert property (@(posedge CLK) disable iff (!rst_n)
    tick |-> (sum - DDA_THRESHOLD < DDA_THRESHOLD));

endmodule

/* verilog/position_snapshot.sv */
`timescale 1ns/1ps

module position_snapshot
  import motion_types_pkg::*;
#(
  parameter int NUM_AXES = 3
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     snap,
  input  step_pos_t [NUM_AXES-1:0] positions,
  input  logic [2:0]               rd_axis,
  output step_pos_t                rd_pos
);

  // All axes taken from the same clock edge
  step_pos_t snap_q [NUM_AXES];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_AXES; i++) begin
        snap_q[i] <= '0;
      end
    end else if (snap) begin
      for (int i = 0; i < NUM_AXES; i++) begin
        snap_q[i] <= positions[i];
      end
    end
  end

  // Read mux, indices past the last axis give zero
  always_comb begin
    rd_pos = '0;
    for (int i = 0; i < NUM_AXES; i++) begin
      if (rd_axis == 3'(i)) begin
        rd_pos = snap_q[i];
      end
    end
  end

endmodule

/* verilog/motion_ctrl_top.sv */
`timescale 1ns/1ps

module motion_ctrl_top
  import motion_types_pkg::*;
#(
  parameter int NUM_AXES = 3
) (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                req,
  input  word_t               word_in,
  output logic                ack,
  output word_t               rsp_word,
  output logic [NUM_AXES-1:0] step,
  output logic [NUM_AXES-1:0] dir,
  output logic                drivers_enable,
  output logic                moves_idle
);

  clk_div_t                 clk_div;
  logic                     snap;
  logic [2:0]               rd_axis;
  step_pos_t                rd_pos;
  step_pos_t [NUM_AXES-1:0] positions;

  move_if mv [NUM_AXES] ();  // One move channel per axis

  cmd_decoder #(
    .NUM_AXES (NUM_AXES)
  ) u_decoder (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .req            (req),
    .word_in        (word_in),
    .ack            (ack),
    .rsp_word       (rsp_word),
    .drivers_enable (drivers_enable),
    .moves_idle     (moves_idle),
    .clk_div        (clk_div),
    .snap           (snap),
    .rd_axis        (rd_axis),
    .rd_pos         (rd_pos),
    .mv             (mv)
  );

  for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
    dda_axis u_axis (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .clk_div  (clk_div),
      .mv       (mv[i]),
      .step     (step[i]),
      .dir      (dir[i]),
      .position (positions[i])
    );
  end

  position_snapshot #(
    .NUM_AXES (NUM_AXES)
  ) u_snapshot (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .snap      (snap),
    .positions (positions),
    .rd_axis   (rd_axis),
    .rd_pos    (rd_pos)
  );

endmodule

/* verification/tb_motion_ref.svh */
`ifndef TB_MOTION_REF_SVH
`define TB_MOTION_REF_SVH

// Steps taken by one axis over a whole move
// residue is the accumulator left from earlier moves and is updated here
function automatic int dda_steps(inout increment_t residue, input increment_t inc,
                                 input increment_t acc, input duration_t dur);
  int         steps;
  int         t;
  increment_t rate;
  steps = 0;
  rate  = inc;
  for (t = 0; t < int'(dur); t++) begin
    residue = residue + rate;
    if (residue >= DDA_THRESHOLD) begin
      residue = residue - DDA_THRESHOLD;  // One step owed
      steps++;
    end
    rate = rate + acc;  // Ramp applies after the tick
  end
  return steps;
endfunction

// Response word the host should see for a command word
function automatic word_t expected_rsp(input word_t cmd, input step_pos_t pos);
  logic [7:0] opc;
  opc = cmd[63:56];
  case (opc)
    CMD_VERSION:  return {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
    CMD_READ_POS: return {{32{pos[31]}}, pos};
    default:      return '0;
  endcase
endfunction

`endif

/* verification/tb_motion_ctrl.sv */
`timescale 1ns/1ps

module tb_motion_ctrl
  import motion_types_pkg::*;
  import motion_cmd_pkg::*;
();

  localparam int NUM_AXES = 3;
  localparam int D_CONST  = 40;
  localparam int D_ACC    = 30;
  localparam int D_BP     = 25;
  localparam int D_DIV    = 20;
  // Worst case 40 clocks per tick plus handshake slack
  localparam int TIMEOUT_CYCLES = (D_CONST + 2 * D_ACC + 2 * D_BP + 2 * D_DIV) * 40 + 2000;

  logic                CLK = 1'b0;
  logic                rst_n;
  logic                req;
  word_t               word_in;
  logic                ack;
  word_t               rsp_word;
  logic [NUM_AXES-1:0] step;
  logic [NUM_AXES-1:0] dir;
  logic                drivers_enable;
  logic                moves_idle;

  int                  seed = 76;
  int                  cycles = 0;
  step_pos_t           model_pos [NUM_AXES];
  increment_t          residue [NUM_AXES];   // Accumulator model per axis
  increment_t          move_inc [NUM_AXES];
  increment_t          move_acc [NUM_AXES];
  logic [NUM_AXES-1:0] cmd_dir;              // Directions of the latest started move

  `include "tb_motion_ref.svh"

  motion_ctrl_top #(
    .NUM_AXES (NUM_AXES)
  ) u_motion_ctrl_top (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .req            (req),
    .word_in        (word_in),
    .ack            (ack),
    .rsp_word       (rsp_word),
    .step           (step),
    .dir            (dir),
    .drivers_enable (drivers_enable),
    .moves_idle     (moves_idle)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("=== FAIL ===");
      $fatal(1, "Run ended by timeout");
    end
  end

  // Step pulses must follow the commanded direction
  always @(negedge CLK) begin
    if (rst_n) begin
      for (int i = 0; i < NUM_AXES; i++) begin
        if (step[i] && dir[i] !== cmd_dir[i]) begin
          $display("Step pulse on axis %0d against the direction of its move", i);
          $display("=== FAIL ===");
          $fatal(1, "Direction check failed");
        end
      end
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Word check failed");
    end
  endtask

  task automatic check_pos(input string name, input step_pos_t got, input step_pos_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Position check failed");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Flag check failed");
    end
  endtask

  // Four-phase host handshake for one word
  task automatic send_word(input word_t w, output word_t rsp);
    @(negedge CLK);
    word_in = w;
    req     = 1'b1;
    @(negedge CLK);
    while (!ack) @(negedge CLK);
    rsp = rsp_word;
    req = 1'b0;
    @(negedge CLK);
    while (ack) @(negedge CLK);
  endtask

  task automatic send_cmd(input word_t w, input step_pos_t pos);
    word_t rsp;
    send_word(w, rsp);
    check_word("rsp_word", rsp, expected_rsp(w, pos));
  endtask

  task automatic random_rates(input logic [31:0] inc_mask, input logic [31:0] acc_mask);
    for (int i = 0; i < NUM_AXES; i++) begin
      move_inc[i] = increment_t'($random(seed) & inc_mask);
      move_acc[i] = increment_t'($random(seed) & acc_mask);
    end
  endtask

  // Header plus increment and accel per axis before the model catches up
  task automatic send_move(input logic [NUM_AXES-1:0] dirs, input duration_t dur);
    word_t rsp;
    word_t hdr;
    int    steps;
    hdr = '0;
    hdr[63:56] = CMD_MOVE;
    hdr[32 +: NUM_AXES] = dirs;
    hdr[31:0] = dur;
    send_cmd(hdr, '0);
    for (int i = 0; i < NUM_AXES; i++) begin
      send_word(word_t'(move_inc[i]), rsp);
      check_word("rsp_word", rsp, '0);
      send_word(word_t'(move_acc[i]), rsp);
      check_word("rsp_word", rsp, '0);
    end
    cmd_dir = dirs;
    for (int i = 0; i < NUM_AXES; i++) begin
      steps = dda_steps(residue[i], move_inc[i], move_acc[i], dur);
      model_pos[i] = dirs[i] ? model_pos[i] + steps : model_pos[i] - steps;
    end
  endtask

  task automatic wait_idle(output int n);
    n = 0;
    while (!moves_idle) begin
      @(negedge CLK);
      n++;
    end
  endtask

  task automatic verify_positions();
    word_t rsp;
    word_t rd;
    send_cmd({CMD_SNAPSHOT, 56'd0}, '0);
    for (int i = 0; i < NUM_AXES; i++) begin
      rd = {CMD_READ_POS, 56'(i)};
      send_word(rd, rsp);
      check_pos($sformatf("position[%0d]", i), step_pos_t'(rsp[31:0]), model_pos[i]);
      check_word("rsp_word", rsp, expected_rsp(rd, model_pos[i]));
    end
  endtask

  initial begin
    int slow_cycles;
    int fast_cycles;
    int n;
    rst_n   = 1'b0;
    req     = 1'b0;
    word_in = '0;
    cmd_dir = '0;
    for (int i = 0; i < NUM_AXES; i++) begin
      model_pos[i] = '0;
      residue[i]   = '0;
    end
    repeat (5) @(negedge CLK);
    rst_n = 1'b1;

    // Reset state and version
    check_bit("ack", ack, 1'b0);
    check_bit("drivers_enable", drivers_enable, 1'b0);
    check_bit("step", |step, 1'b0);
    check_bit("moves_idle", moves_idle, 1'b1);
    send_cmd({CMD_VERSION, 56'd0}, '0);

    send_cmd({CMD_ENABLE, 56'd1}, '0);
    check_bit("drivers_enable", drivers_enable, 1'b1);
    send_cmd({CMD_ENABLE, 56'd0}, '0);
    check_bit("drivers_enable", drivers_enable, 1'b0);
    send_cmd({CMD_ENABLE, 56'd1}, '0);

    // Constant rate with mixed directions
    random_rates(32'h7FFF_FFFF, 32'h0);
    send_move(3'b101, D_CONST);
    wait_idle(n);
    verify_positions();

    // Ramped moves with the residue carried into the second
    random_rates(32'h0FFF_FFFF, 32'h000F_FFFF);
    send_move(3'b011, D_ACC);
    wait_idle(n);
    verify_positions();
    random_rates(32'h0FFF_FFFF, 32'h000F_FFFF);
    send_move(3'b110, D_ACC);
    wait_idle(n);
    verify_positions();

    // Second move queued behind a running one
    random_rates(32'h7FFF_FFFF, 32'h0);
    send_move(3'b010, D_BP);
    check_bit("moves_idle", moves_idle, 1'b0);
    random_rates(32'h7FFF_FFFF, 32'h0);
    send_move(3'b101, D_BP);
    wait_idle(n);
    verify_positions();

    // Same length at divisor 39 and then at divisor 0
    random_rates(32'h7FFF_FFFF, 32'h0);
    send_move(3'b111, D_DIV);
    wait_idle(slow_cycles);
    verify_positions();
    send_cmd({CMD_CLK_DIVISOR, 56'd0}, '0);
    random_rates(32'h7FFF_FFFF, 32'h0);
    send_move(3'b001, D_DIV);
    wait_idle(fast_cycles);
    verify_positions();
    send_cmd({CMD_READ_POS, 56'd5}, '0);  // Past the last axis

    if (fast_cycles >= slow_cycles) begin
      $display("Divisor 0 took %0d cycles, not fewer than %0d at divisor 39",
               fast_cycles, slow_cycles);
      $display("=== FAIL ===");
      $fatal(1, "Clock divisor had no effect");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

/* filelist.f */
+incdir+verification
common/motion_types_pkg.sv
common/motion_cmd_pkg.sv
common/move_if.sv
verilog/cmd_decoder/cmd_decoder.sv
verilog/dda_axis/dda_axis.sv
verilog/position_snapshot.sv
verilog/motion_ctrl_top.sv
verification/tb_motion_ctrl.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_motion_ctrl \
  -f filelist.f \
  -o sim_motion_ctrl

./obj_dir/sim_motion_ctrl | tee /dev/stderr | grep -qx '=== PASS ==='
